// File: src.f
+incdir+verilog
verilog/mapper_pkg.sv
verilog/mapper_decode.sv
verilog/mapper_bank_regs.sv
verilog/mapper_addr_out.sv
verilog/mapper_slot.sv
testbench/mapper_slot_assertions.sv
testbench/mapper_slot_tb.sv

// File: Makefile
TOP = mapper_slot_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

// File: testbench/mapper_slot_tb.sv
`include "mapper_params.svh"

module mapper_slot_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 32;   // Upper bound of the directed part
    localparam int GM2_CYCLES      = 400;
    localparam int ASCII8_CYCLES   = 400;
    localparam int NONE_CYCLES     = 100;
    localparam int MARGIN_CYCLES   = 100;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + GM2_CYCLES
                                     + ASCII8_CYCLES + NONE_CYCLES;

    logic                    cpu_bus;
    logic                    rst_n;
    mapper_pkg::cpu_req_t    req;
    mapper_pkg::block_info_t block_info;
    mapper_pkg::mem_req_t    out;

    integer     seed;              // $random state
    logic [7:0] model_bank [4];    // Reference copy of the bank registers

    mapper_slot mapper_slot_inst (
        .cpu_bus    (cpu_bus),
        .rst_n      (rst_n),
        .req        (req),
        .block_info (block_info),
        .out        (out)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_bus = ~cpu_bus;
    end

    // Watchdog sized from the phase lengths
    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    // Expected outputs for one request from the current model banks
    function automatic mapper_pkg::mem_req_t expect_out(input mapper_pkg::cpu_req_t r,
                                                        input mapper_pkg::mapper_typ_e t);
        mapper_pkg::mem_req_t e;
        logic [15:0]          off;
        logic [1:0]           win;
        logic [7:0]           bw;
        logic [7:0]           page;
        logic                 in_win;

        e.ram_cs  = 1'b0;
        e.sram_cs = 1'b0;
        e.rnw     = 1'b1;
        e.addr    = '1;  // Idle unless something is selected
        in_win    = (r.addr >= 16'h4000) && (r.addr <= 16'hBFFF);
        off       = r.addr - 16'h4000;
        win       = off[14:13];  // 8 KB steps from 4000h
        if (t == mapper_pkg::MAPPER_NONE || !r.mreq || !in_win) begin
            return e;
        end
        bw = (t == mapper_pkg::MAPPER_GM2 && win == 2'd0) ? 8'h00 : model_bank[win];
        if (t == mapper_pkg::MAPPER_GM2 && bw[4]) begin
            e.sram_cs     = 1'b1;
            e.addr        = '0;
            e.addr[12]    = bw[5];         // SRAM page
            e.addr[11:0]  = r.addr[11:0];  // 4 KB mirrored
            e.rnw         = !(r.wr && r.addr[15:12] == 4'hB);
        end else if (r.rd) begin
            page          = (t == mapper_pkg::MAPPER_GM2) ? {4'h0, bw[3:0]} : bw;
            e.ram_cs      = 1'b1;
            e.addr        = '0;
            e.addr[20:13] = page;
            e.addr[12:0]  = r.addr[12:0];
        end
        return e;
    endfunction

    // Bank register writes of the model seen from the next edge on
    function automatic void update_model(input mapper_pkg::cpu_req_t r,
                                         input mapper_pkg::mapper_typ_e t);
        if (!r.mreq || !r.wr) begin
            return;
        end
        if (t == mapper_pkg::MAPPER_GM2) begin
            case (r.addr[15:12])
                4'h6: model_bank[1] = r.data & 8'h3F;
                4'h8: model_bank[2] = r.data & 8'h3F;
                4'hA: model_bank[3] = r.data & 8'h3F;
                default: ;  // 4xxxh and the rest change nothing
            endcase
        end else if (t == mapper_pkg::MAPPER_ASCII8) begin
            if (r.addr >= 16'h6000 && r.addr < 16'h6800) begin
                model_bank[0] = r.data;
            end else if (r.addr >= 16'h6800 && r.addr < 16'h7000) begin
                model_bank[1] = r.data;
            end else if (r.addr >= 16'h7000 && r.addr < 16'h7800) begin
                model_bank[2] = r.data;
            end else if (r.addr >= 16'h7800 && r.addr < 16'h8000) begin
                model_bank[3] = r.data;
            end
        end
    endfunction

    task automatic stop_on_failure();
        $display("Test FAILED");
        $fatal(1, "Slot output mismatch");
    endtask

    task automatic check_mem_req(input mapper_pkg::mem_req_t expected,
                                 input mapper_pkg::mem_req_t actual);
        if (actual.ram_cs !== expected.ram_cs) begin
            $display("FAILED at %0t: out.ram_cs expected %0b, got %0b",
                     $time, expected.ram_cs, actual.ram_cs);
            stop_on_failure();
        end
        if (actual.sram_cs !== expected.sram_cs) begin
            $display("FAILED at %0t: out.sram_cs expected %0b, got %0b",
                     $time, expected.sram_cs, actual.sram_cs);
            stop_on_failure();
        end
        if (actual.rnw !== expected.rnw) begin
            $display("FAILED at %0t: out.rnw expected %0b, got %0b",
                     $time, expected.rnw, actual.rnw);
            stop_on_failure();
        end
        if (actual.addr !== expected.addr) begin
            $display("FAILED at %0t: out.addr expected %07h, got %07h",
                     $time, expected.addr, actual.addr);
            stop_on_failure();
        end
    endtask

    // One bus cycle with drive on the rising edge and check on the falling edge
    task automatic run_cycle(input mapper_pkg::cpu_req_t r,
                             input mapper_pkg::mapper_typ_e t);
        @(posedge cpu_bus);
        req             <= r;
        block_info.typ  <= t;
        @(negedge cpu_bus);
        check_mem_req(expect_out(r, t), out);
        update_model(r, t);
    endtask

    task automatic cpu_read(input logic [15:0] a, input mapper_pkg::mapper_typ_e t);
        mapper_pkg::cpu_req_t r;
        r      = '0;
        r.addr = a;
        r.rd   = 1'b1;
        r.mreq = 1'b1;
        run_cycle(r, t);
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d,
                             input mapper_pkg::mapper_typ_e t);
        mapper_pkg::cpu_req_t r;
        r      = '0;
        r.addr = a;
        r.data = d;
        r.wr   = 1'b1;
        r.mreq = 1'b1;
        run_cycle(r, t);
    endtask

    task automatic read_each_window(input mapper_pkg::mapper_typ_e t);
        cpu_read(16'h4123, t);
        cpu_read(16'h6123, t);
        cpu_read(16'h8123, t);
        cpu_read(16'hA123, t);
    endtask

    // Random read, write, idle or refresh-like cycle over the full address space
    task automatic random_req(output mapper_pkg::cpu_req_t r);
        logic [31:0] rnd;
        logic [2:0]  op;
        rnd    = $random(seed);
        op     = rnd[26:24];
        r.addr = rnd[15:0];
        r.data = rnd[23:16];
        r.mreq = (op != 3'd6);
        r.rd   = (op <= 3'd2) || (op == 3'd6 && rnd[27]);
        r.wr   = (op >= 3'd3 && op <= 3'd5) || (op == 3'd6 && rnd[28]);
    endtask

    task automatic random_phase(input mapper_pkg::mapper_typ_e t, input int cycles);
        mapper_pkg::cpu_req_t r;
        for (int n = 0; n < cycles; n++) begin
            random_req(r);
            run_cycle(r, t);
        end
    endtask

    initial begin
        seed           = 32'h246a2ec2;
        rst_n          = 1'b0;
        req            = '0;
        block_info.typ = mapper_pkg::MAPPER_NONE;
        model_bank[0]  = `MAPPER_BANK_RST0;
        model_bank[1]  = `MAPPER_BANK_RST1;
        model_bank[2]  = `MAPPER_BANK_RST2;
        model_bank[3]  = `MAPPER_BANK_RST3;

        repeat (RESET_CYCLES) @(posedge cpu_bus);
        rst_n <= 1'b1;

        // Reset defaults give pages 0 to 3
        read_each_window(mapper_pkg::MAPPER_GM2);
        read_each_window(mapper_pkg::MAPPER_ASCII8);

        // GameMaster2 banks and SRAM
        cpu_write(16'h6000, 8'h05, mapper_pkg::MAPPER_GM2);
        cpu_read(16'h6010, mapper_pkg::MAPPER_GM2);           // Page 5
        cpu_write(16'h4000, 8'h07, mapper_pkg::MAPPER_GM2);   // No register there
        read_each_window(mapper_pkg::MAPPER_ASCII8);          // Raw banks still 0, 5, 2, 3
        cpu_write(16'hA000, 8'h30, mapper_pkg::MAPPER_GM2);   // SRAM page 1
        cpu_write(16'hB456, 8'h5A, mapper_pkg::MAPPER_GM2);   // SRAM write strobe
        cpu_write(16'hA456, 8'h5A, mapper_pkg::MAPPER_GM2);   // Register write with rnw high
        cpu_read(16'hB456, mapper_pkg::MAPPER_GM2);
        cpu_write(16'h8000, 8'hFF, mapper_pkg::MAPPER_GM2);   // Masked to 3Fh
        cpu_read(16'h9ABC, mapper_pkg::MAPPER_GM2);

        // ASCII8 full byte pages
        cpu_write(16'h6000, 8'hC1, mapper_pkg::MAPPER_ASCII8);
        cpu_write(16'h6800, 8'hC2, mapper_pkg::MAPPER_ASCII8);
        cpu_write(16'h7000, 8'hC3, mapper_pkg::MAPPER_ASCII8);
        cpu_write(16'h7800, 8'hD4, mapper_pkg::MAPPER_ASCII8);
        read_each_window(mapper_pkg::MAPPER_ASCII8);
        cpu_read(16'h2000, mapper_pkg::MAPPER_ASCII8);        // Outside the slot
        cpu_read(16'h6000, mapper_pkg::MAPPER_NONE);

        random_phase(mapper_pkg::MAPPER_GM2, GM2_CYCLES);
        random_phase(mapper_pkg::MAPPER_ASCII8, ASCII8_CYCLES);
        random_phase(mapper_pkg::MAPPER_NONE, NONE_CYCLES);

        @(posedge cpu_bus);
        req <= '0;
        @(negedge cpu_bus);

        if (mapper_slot_inst.mapper_slot_assertions_inst.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d assertion failures on the slot outputs",
                     mapper_slot_inst.mapper_slot_assertions_inst.fail_count);
            $display("Test FAILED");
            $fatal(1, "Assertions failed");
        end
    end

endmodule

// File: testbench/mapper_slot_assertions.sv
module mapper_slot_assertions (
    input logic                 cpu_bus,
    input logic                 rst_n,
    input mapper_pkg::cpu_req_t req,
    input mapper_pkg::mem_req_t out
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // Failed assertions so far

    // ROM and SRAM never share a cycle
    one_select: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        !(out.ram_cs && out.sram_cs))
    else begin
        fail_count <= fail_count + 1;
        $error("ram_cs and sram_cs are both high");
    end

    // Idle address on the bus when nothing is selected
    idle_addr: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        (!out.ram_cs && !out.sram_cs) |-> (out.addr == '1))
    else begin
        fail_count <= fail_count + 1;
        $error("addr is not all ones while no chip is selected");
    end

    // Write strobe only toward SRAM during a CPU write
    write_strobe: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        !out.rnw |-> (out.sram_cs && req.wr))
    else begin
        fail_count <= fail_count + 1;
        $error("rnw is low outside an SRAM write");
    end

endmodule

bind mapper_slot mapper_slot_assertions mapper_slot_assertions_inst (
    .cpu_bus (cpu_bus),
    .rst_n   (rst_n),
    .req     (req),
    .out     (out)
);

// File: verilog/mapper_slot.sv
module mapper_slot (
    input  logic                    cpu_bus,
    input  logic                    rst_n,
    input  mapper_pkg::cpu_req_t    req,
    input  mapper_pkg::block_info_t block_info,
    output mapper_pkg::mem_req_t    out
);

    mapper_pkg::slot_dec_t  dec;   // Window and register decode
    mapper_pkg::bank_word_u bank;  // Bank of the addressed window

    // Address and strobe decode
    mapper_decode mapper_decode_inst (
        .req (req),
        .typ (block_info.typ),
        .dec (dec)
    );

    // Bank registers, the only clocked part
    mapper_bank_regs mapper_bank_regs_inst (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .typ     (block_info.typ),
        .dec     (dec),
        .data    (req.data),
        .bank    (bank)
    );

    // Memory address and chip selects
    mapper_addr_out mapper_addr_out_inst (
        .req  (req),
        .typ  (block_info.typ),
        .dec  (dec),
        .bank (bank),
        .out  (out)
    );

endmodule

// File: verilog/mapper_addr_out.sv
`include "mapper_params.svh"

module mapper_addr_out (
    input  mapper_pkg::cpu_req_t    req,
    input  mapper_pkg::mapper_typ_e typ,
    input  mapper_pkg::slot_dec_t   dec,
    input  mapper_pkg::bank_word_u  bank,
    output mapper_pkg::mem_req_t    out
);

    // Zero fill above the page bits
    localparam int ROM_PAD_W  = `MAPPER_ADDR_W - 8 - `MAPPER_ROM_OFS_W;
    localparam int SRAM_PAD_W = `MAPPER_ADDR_W - 1 - `MAPPER_SRAM_OFS_W;

    logic                      is_gm2;
    logic                      mapper_en;
    logic                      sel;        // Slot owns this cycle
    logic                      sram_sel;   // Bank maps SRAM
    logic [7:0]                rom_page;
    logic [`MAPPER_ADDR_W-1:0] rom_addr;
    logic [`MAPPER_ADDR_W-1:0] sram_addr;

    assign is_gm2    = (typ == mapper_pkg::MAPPER_GM2);
    assign mapper_en = is_gm2 || (typ == mapper_pkg::MAPPER_ASCII8);
    assign sel       = req.mreq && dec.in_window && mapper_en;

    // Only GameMaster2 reads the SRAM view of the bank word
    assign sram_sel = sel && is_gm2 && bank.sram.sram_en;

    // GameMaster2 pages are 4 bits, ASCII8 uses the full byte
    assign rom_page = is_gm2 ? {4'b0000, bank.rom[3:0]} : bank.rom;

    assign rom_addr  = {{ROM_PAD_W{1'b0}}, rom_page,
                        req.addr[`MAPPER_ROM_OFS_W-1:0]};
    assign sram_addr = {{SRAM_PAD_W{1'b0}}, bank.sram.sram_page,
                        req.addr[`MAPPER_SRAM_OFS_W-1:0]};  // 4 KB mirrored twice

    always_comb begin
        out.sram_cs = sram_sel;
        out.ram_cs  = sel && req.rd && !sram_sel;  // ROM is read only

        // Write strobe to SRAM only inside BxxxH
        out.rnw = !(out.sram_cs && req.wr && dec.sram_wr_area);

        // Idle address whenever no chip is selected,
        // which also covers ROM windows seen on a write cycle
        if (out.sram_cs) begin
            out.addr = sram_addr;
        end else if (out.ram_cs) begin
            out.addr = rom_addr;
        end else begin
            out.addr = '1;
        end
    end

endmodule

// File: verilog/mapper_bank_regs.sv
`include "mapper_params.svh"

module mapper_bank_regs (
    input  logic                    cpu_bus,
    input  logic                    rst_n,
    input  mapper_pkg::mapper_typ_e typ,
    input  mapper_pkg::slot_dec_t   dec,
    input  logic [7:0]              data,
    output mapper_pkg::bank_word_u  bank
);

    mapper_pkg::bank_word_u bank_q [4];  // One bank per 8 KB window

    logic       is_gm2;
    logic       wr_en;    // Qualified register write
    logic [7:0] wr_data;  // Write data after per-mapper masking

    assign is_gm2 = (typ == mapper_pkg::MAPPER_GM2);

    // GameMaster2 bank 0 is fixed, keep its register at the reset value
    assign wr_en = dec.reg_wr && !(is_gm2 && (dec.reg_sel == 2'd0));

    // GameMaster2 banks are 6 bits wide
    // Bits 3:0 ROM page, bit 4 SRAM enable, bit 5 SRAM page
    assign wr_data = is_gm2 ? {2'b00, data[5:0]} : data;

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            bank_q[0].rom <= `MAPPER_BANK_RST0;
            bank_q[1].rom <= `MAPPER_BANK_RST1;
            bank_q[2].rom <= `MAPPER_BANK_RST2;
            bank_q[3].rom <= `MAPPER_BANK_RST3;
        end else if (wr_en) begin
            bank_q[dec.reg_sel].rom <= wr_data;  // Visible from the next cycle
        end
    end

    // Bank of the current window
    always_comb begin
        if (is_gm2 && (dec.window == 2'd0)) begin
            bank = '0;  // 4000h..5FFFh always ROM page 0
        end else begin
            bank = bank_q[dec.window];
        end
    end

endmodule

// File: verilog/mapper_decode.sv
module mapper_decode (
    input  mapper_pkg::cpu_req_t    req,
    input  mapper_pkg::mapper_typ_e typ,
    output mapper_pkg::slot_dec_t   dec
);

    logic       is_gm2;     // GameMaster2 register map
    logic       is_ascii8;  // ASCII8 register map
    logic       wr_cyc;     // CPU memory write strobe
    logic [3:0] nib;        // Top address nibble, 4 KB steps

    assign is_gm2    = (typ == mapper_pkg::MAPPER_GM2);
    assign is_ascii8 = (typ == mapper_pkg::MAPPER_ASCII8);
    assign wr_cyc    = req.mreq && req.wr;
    assign nib       = req.addr[15:12];

    always_comb begin
        dec = '0;

        // Window index kept even with no mapper, it costs nothing
        // 4000h -> 0, 6000h -> 1, 8000h -> 2, A000h -> 3
        dec.window = req.addr[14:13] - 2'd2;

        if (is_gm2 || is_ascii8) begin
            // Bits 15 and 14 differ only inside 4000h..BFFFh
            dec.in_window = req.addr[15] ^ req.addr[14];
        end

        if (is_gm2) begin
            // Registers sit at the start of windows 1 to 3
            // Bank 0 is hardwired, so 4xxxh writes go nowhere
            case (nib)
                4'h6: begin
                    dec.reg_sel = 2'd1;
                    dec.reg_wr  = wr_cyc;
                end
                4'h8: begin
                    dec.reg_sel = 2'd2;
                    dec.reg_wr  = wr_cyc;
                end
                4'hA: begin
                    dec.reg_sel = 2'd3;
                    dec.reg_wr  = wr_cyc;
                end
                default: begin
                    dec.reg_sel = 2'd0;  // No register here
                    dec.reg_wr  = 1'b0;
                end
            endcase

            dec.sram_wr_area = (nib == 4'hB);  // SRAM writes only through BxxxH
        end

        if (is_ascii8) begin
            // 6000h..7FFFh split in four 2 KB register ranges
            if (req.addr[15:13] == 3'b011) begin
                dec.reg_sel = req.addr[12:11];  // 6000h, 6800h, 7000h, 7800h
                dec.reg_wr  = wr_cyc;
            end
        end
    end

endmodule

// File: verilog/mapper_pkg.sv
`include "mapper_params.svh"

package mapper_pkg;

    // Mapper type from the cartridge configuration
    typedef enum logic [1:0] {
        MAPPER_NONE   = 2'd0,  // Slot empty, all outputs idle
        MAPPER_GM2    = 2'd1,  // GameMaster2 with battery SRAM
        MAPPER_ASCII8 = 2'd2   // ASCII8, four 8 KB ROM banks
    } mapper_typ_e;

    // CPU memory cycle as plain levels
    typedef struct packed {
        logic [`MAPPER_CPU_ADDR_W-1:0] addr;
        logic [7:0]                    data;  // Write data
        logic                          rd;
        logic                          wr;
        logic                          mreq;
    } cpu_req_t;

    // Slot configuration
    typedef struct packed {
        mapper_typ_e typ;
    } block_info_t;

    // SRAM view of a GameMaster2 bank word
    typedef struct packed {
        logic [1:0] unused_hi;
        logic       sram_page;  // Bit 5, picks one of two 4 KB SRAM pages
        logic       sram_en;    // Bit 4, bank maps SRAM instead of ROM
        logic [3:0] unused_lo;  // ROM page bits, not part of this view
    } bank_sram_t;

    // One bank register, read as a ROM page or as SRAM control
    typedef union packed {
        logic [7:0] rom;        // ASCII8 uses all 8 bits, GameMaster2 the low 4
        bank_sram_t sram;
    } bank_word_u;

    // Address decode result
    typedef struct packed {
        logic [1:0] window;        // 8 KB window, 4000h is window 0
        logic       in_window;     // Address in 4000h..BFFFh
        logic       reg_wr;        // Bank register write this cycle
        logic [1:0] reg_sel;       // Which bank register
        logic       sram_wr_area;  // BxxxH, the only SRAM write range
    } slot_dec_t;

    // Memory side request
    typedef struct packed {
        logic                      ram_cs;   // Cartridge ROM image in main RAM
        logic                      sram_cs;  // Battery backed SRAM
        logic                      rnw;      // High for read
        logic [`MAPPER_ADDR_W-1:0] addr;
    } mem_req_t;

endpackage

// File: verilog/mapper_params.svh
`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

// Memory side address width, 128 MB of main RAM space
`define MAPPER_ADDR_W       27

// CPU address width
`define MAPPER_CPU_ADDR_W   16

// Offset bits inside an 8 KB ROM page
`define MAPPER_ROM_OFS_W    13

// Offset bits inside a 4 KB SRAM page, mirrored over the 8 KB window
`define MAPPER_SRAM_OFS_W   12

// Bank register values after reset
// Windows 4000h, 6000h, 8000h and A000h map ROM pages 0 to 3
`define MAPPER_BANK_RST0    8'h00
`define MAPPER_BANK_RST1    8'h01
`define MAPPER_BANK_RST2    8'h02
`define MAPPER_BANK_RST3    8'h03

`endif
